/* build.f */
+incdir+.
decode_pkg.sv
insn_field_decoder.sv
imm_gen.sv
credit_counter.sv
stage_ctrl.sv
decode_stage.sv
tb_clock_gen.sv
decode_tb.sv

/* Makefile */
TOP = decode_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module decode_stage \
		decode_pkg.sv insn_field_decoder.sv imm_gen.sv \
		credit_counter.sv stage_ctrl.sv decode_stage.sv
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Builds a word of the chosen instruction group with free fields taken from r
function automatic insn_t make_insn(input int unsigned kind, input int unsigned sel,
                                    input insn_t r);
    begin
        case (kind)
            0: make_insn = {10'h000, 7'h20 + 7'(sel % 17), r[14:0]};   // Includes gaps
            1: make_insn = {10'h001, 2'b00, 2'(sel % 3), 3'b001, r[14:0]};
            2: make_insn = {6'd0, 4'h8 + 4'(sel % 8), r[21:0]};
            3: make_insn = {4'b0001, sel[0], 2'b10, r[24:0]};
            4: make_insn = {6'b001010, 4'(sel % 12), r[21:0]};
            5: make_insn = {17'b0011_1000_0111_0010_0, r[14:0]};         // DBAR
            6: make_insn = {10'h000, 5'b10101, sel[0], 1'b0, r[14:0]};   // BREAK, SYSCALL
            7:
            begin
                if (sel % 4 == 0)
                    make_insn = {6'b010011, 16'd0, 5'd1, 5'd0};          // jirl r0, ra, 0
                else if (sel % 4 == 1)
                    make_insn = {6'b010011, r[25:5], 5'd1};
                else
                    make_insn = {6'b010011, r[25:0]};
            end
            8: make_insn = {6'd20 + 6'(sel % 2), r[25:0]};
            9: make_insn = {6'd22 + 6'(sel % 6), r[25:0]};
            default: make_insn = r;
        endcase
    end
endfunction

task automatic clear_expected();
    begin
        exp_class     = UOP_EXCEPTION;
        exp_alu       = ALU_AND;
        exp_sub       = '0;
        exp_rj        = '0;
        exp_rk        = '0;
        exp_rd        = '0;
        exp_imm       = '0;
        exp_src1_pc   = 1'b0;
        exp_src2_imm  = 1'b0;
        exp_reg_write = 1'b0;
        exp_jump      = JK_NOT_JUMP;
        exp_excp      = EXC_INE;
    end
endtask

task automatic expect_uop(input uop_class_e c, input alu_op_e a, input logic wr,
                          input logic s1, input logic s2, input insn_t w);
    begin
        exp_class     = c;
        exp_alu       = a;
        exp_reg_write = wr;
        exp_src1_pc   = s1;
        exp_src2_imm  = s2;
        exp_rj        = w[9:5];
        exp_rd        = w[4:0];
        exp_excp      = '0;
    end
endtask

task automatic predict_uop(input insn_t w, input addr_t pa);
    alu_op_e    a;
    logic [3:0] f4;
    logic [6:0] f7;
    begin
        f4 = w[25:22];
        f7 = w[21:15];
        clear_expected();
        if (w[31:22] == 10'h000)
        begin
            a = ALU_PASS_B;                     // No 3R match yet
            case (f7)
                7'h20: a = ALU_ADD;
                7'h22: a = ALU_SUB;
                7'h24: a = ALU_SLT;
                7'h25: a = ALU_SLTU;
                7'h28: a = ALU_NOR;
                7'h29: a = ALU_AND;
                7'h2a: a = ALU_OR;
                7'h2b: a = ALU_XOR;
                7'h2e: a = ALU_SLL;
                7'h2f: a = ALU_SRL;
                7'h30: a = ALU_SRA;
                7'h54: exp_excp = EXC_BRK;
                7'h56: exp_excp = EXC_SYS;
                default: ;
            endcase
            if (a != ALU_PASS_B)
            begin
                expect_uop(UOP_ALU, a, 1'b1, 1'b0, 1'b0, w);
                exp_rk = w[14:10];
            end
        end
        else if (w[31:22] == 10'h001 && (f7 == 7'h01 || f7 == 7'h09 || f7 == 7'h11))
        begin
            a = (f7 == 7'h01) ? ALU_SLL : ((f7 == 7'h09) ? ALU_SRL : ALU_SRA);
            expect_uop(UOP_ALU, a, 1'b1, 1'b0, 1'b1, w);
            exp_imm = {27'd0, w[14:10]};
        end
        else if (w[31:26] == 6'd0 && f4 inside {4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf})
        begin
            case (f4)
                4'h8: a = ALU_SLT;
                4'h9: a = ALU_SLTU;
                4'ha: a = ALU_ADD;
                4'hd: a = ALU_AND;
                4'he: a = ALU_OR;
                default: a = ALU_XOR;
            endcase
            expect_uop(UOP_ALU, a, 1'b1, 1'b0, 1'b1, w);
            exp_imm = (f4 < 4'hd) ? imm_t'($signed(w[21:10])) : {20'd0, w[21:10]};
        end
        else if (w[31:26] == 6'b000101 && !w[25] || w[31:26] == 6'b000111 && !w[25])
        begin
            a = w[27] ? ALU_ADD : ALU_PASS_B;   // PCADDU12I adds to pc
            expect_uop(UOP_ALU, a, 1'b1, w[27], 1'b1, w);
            exp_rj  = '0;
            exp_imm = {w[24:5], 12'd0};
        end
        else if (w[31:26] == 6'b001010 && f4 == 4'hb)
        begin
            exp_class = UOP_NOP;                // PRELD
            exp_excp  = '0;
        end
        else if (w[31:26] == 6'b001010 && f4 inside {[4'h0:4'h2], [4'h4:4'h6], 4'h8, 4'h9})
        begin
            if (f4 inside {[4'h4:4'h6]})
                expect_uop(UOP_STORE, ALU_ADD, 1'b0, 1'b0, 1'b1, w);
            else
                expect_uop(UOP_LOAD, ALU_ADD, 1'b1, 1'b0, 1'b1, w);
            exp_sub = (f4 < 4'h4) ? f4 : ((f4 < 4'h8) ? f4 - 4'd1 : f4 - 4'd2);
            exp_imm = imm_t'($signed(w[21:10]));
        end
        else if (w[31:15] == 17'b0011_1000_0111_0010_0)
        begin
            exp_class = UOP_NOP;
            exp_excp  = '0;
        end
        else if (w[31:26] == 6'b010011)
        begin
            expect_uop(UOP_JUMP_LINK, ALU_ADD, 1'b1, 1'b1, 1'b0, w);
            exp_imm = imm_t'($signed({w[25:10], 2'b00}));
            if (w[4:0] == 5'd0 && w[9:5] == 5'd1 && w[25:10] == 16'd0)
                exp_jump = JK_RET;
            else if (w[4:0] == 5'd1)
                exp_jump = JK_CALL;
            else
                exp_jump = JK_INDIRECT;
        end
        else if (w[31:26] == 6'b010100 || w[31:26] == 6'b010101)
        begin
            if (w[26])
                expect_uop(UOP_JUMP_LINK, ALU_ADD, 1'b1, 1'b1, 1'b0, w);
            else
                expect_uop(UOP_BRANCH, ALU_AND, 1'b0, 1'b0, 1'b0, w);
            exp_rj   = '0;
            exp_rd   = w[26] ? 5'd1 : 5'd0;     // BL writes ra
            exp_jump = w[26] ? JK_CALL : JK_JUMP;
            exp_imm  = imm_t'($signed({w[9:0], w[25:10], 2'b00}));
        end
        else if (w[31:26] inside {[6'd22:6'd27]})
        begin
            case (w[31:26])
                6'd22, 6'd23: a = ALU_SUB;
                6'd24, 6'd25: a = ALU_SLT;
                default:      a = ALU_SLTU;
            endcase
            expect_uop(UOP_BRANCH, a, 1'b0, 1'b0, 1'b0, w);
            exp_sub  = sub_op_t'(w[31:26] - 6'd21);
            exp_jump = JK_DIRECT;
            exp_imm  = imm_t'($signed({w[25:10], 2'b00}));
        end

        if (pa[1:0] != 2'b00)
        begin
            clear_expected();
            exp_excp = EXC_ADEF;
        end
    end
endtask

`endif

/* decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    insn_t      insn;
    addr_t      pc;
    logic       credit_return;
    logic       flush;
    logic       in_ready;
    logic       out_valid;
    uop_class_e uop_class;
    alu_op_e    alu_op;
    sub_op_t    sub_op;
    reg_idx_t   rj;
    reg_idx_t   rk;
    reg_idx_t   rd;
    imm_t       imm;
    logic       src1_pc;
    logic       src2_imm;
    logic       reg_write;
    jump_kind_e jump_kind;
    excp_code_t excp_code;

    uop_class_e exp_class;
    alu_op_e    exp_alu;
    sub_op_t    exp_sub;
    reg_idx_t   exp_rj;
    reg_idx_t   exp_rk;
    reg_idx_t   exp_rd;
    imm_t       exp_imm;
    logic       exp_src1_pc;
    logic       exp_src2_imm;
    logic       exp_reg_write;
    jump_kind_e exp_jump;
    excp_code_t exp_excp;

    int    value_errors = 0;
    int    flow_errors  = 0;
    int    n_accepted   = 0;
    int    in_flight    = 0;    // Micro-ops received minus credits returned
    int    cycle        = 0;
    int    flush_due    = -1;
    int    return_due[$];
    logic  accepted     = 1'b0; // Accept at the coming edge
    logic  pending      = 1'b0; // Micro-op due on out_valid this cycle
    logic  holding      = 1'b0;
    insn_t pend_insn;
    addr_t pend_pc;

    `include "tb_ref_model.svh"

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .insn          (insn),
        .pc            (pc),
        .credit_return (credit_return),
        .flush         (flush),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .uop_class     (uop_class),
        .alu_op        (alu_op),
        .sub_op        (sub_op),
        .rj            (rj),
        .rk            (rk),
        .rd            (rd),
        .imm           (imm),
        .src1_pc       (src1_pc),
        .src2_imm      (src2_imm),
        .reg_write     (reg_write),
        .jump_kind     (jump_kind),
        .excp_code     (excp_code)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want, input logic is_flow);
        begin
            assert (got === want)
            else
            begin
                if (is_flow)
                    flow_errors++;
                else
                    value_errors++;
                $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            end
        end
    endtask

    task automatic drive_next();
        int unsigned kind;
        int unsigned sel;
        addr_t       addr;
        begin
            kind      = $urandom % 11;
            sel       = $urandom;
            addr      = $urandom;
            addr[1:0] = ($urandom % 16 == 0) ? 2'(1 + $urandom % 3) : 2'b00;
            in_valid <= ($urandom % 4 != 0);
            insn     <= make_insn(kind, sel, $urandom);
            pc       <= addr;
        end
    endtask

    // Downstream consumer that returns credits and flushes after exceptions
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycle++;
            credit_return <= 1'b0;
            if (return_due.size() > 0 && return_due[0] <= cycle)
            begin
                void'(return_due.pop_front());
                credit_return <= 1'b1;
            end
            flush <= (cycle == flush_due);
        end
    end

    // Scoreboard on the falling edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            check_value("out_valid", 32'(out_valid), 32'(pending), 1'b1);
            if (out_valid)
            begin
                in_flight++;
                return_due.push_back(cycle + 1 + int'($urandom % 6));
            end
            if (out_valid && pending)
            begin
                predict_uop(pend_insn, pend_pc);
                check_value("uop_class", 32'(uop_class), 32'(exp_class), 1'b0);
                check_value("alu_op", 32'(alu_op), 32'(exp_alu), 1'b0);
                check_value("sub_op", 32'(sub_op), 32'(exp_sub), 1'b0);
                check_value("rj", 32'(rj), 32'(exp_rj), 1'b0);
                check_value("rk", 32'(rk), 32'(exp_rk), 1'b0);
                check_value("rd", 32'(rd), 32'(exp_rd), 1'b0);
                check_value("imm", imm, exp_imm, 1'b0);
                check_value("src1_pc", 32'(src1_pc), 32'(exp_src1_pc), 1'b0);
                check_value("src2_imm", 32'(src2_imm), 32'(exp_src2_imm), 1'b0);
                check_value("reg_write", 32'(reg_write), 32'(exp_reg_write), 1'b0);
                check_value("jump_kind", 32'(jump_kind), 32'(exp_jump), 1'b0);
                check_value("excp_code", 32'(excp_code), 32'(exp_excp), 1'b0);
                if (exp_class == UOP_EXCEPTION)
                begin
                    holding   = 1'b1;
                    flush_due = cycle + 2 + int'($urandom % 4);
                end
            end
            assert (in_flight <= CREDITS)
            else
            begin
                flow_errors++;
                $display("more micro-ops outstanding than credits granted at %0t ns", $time);
            end
            check_value("in_ready", 32'(in_ready), 32'(!holding && in_flight < CREDITS), 1'b1);
            accepted = in_valid && in_ready;
            pending  = in_valid && !holding && in_flight < CREDITS;
            if (pending)
            begin
                pend_insn = insn;
                pend_pc   = pc;
            end
            if (accepted)
                n_accepted++;
            if (credit_return)
                in_flight--;
            if (flush)
                holding = 1'b0;     // Stage runs again after this edge
        end
    end

    initial
    begin
        void'($urandom(32'hbab9));
        in_valid      = 1'b0;
        insn          = '0;
        pc            = '0;
        credit_return = 1'b0;
        flush         = 1'b0;
        wait (rst_n);
        while (n_accepted < 2000)
        begin
            @(posedge clk);
            if (accepted || !in_valid)
                drive_next();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait (in_flight == 0 && !holding && !pending);
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d flow control, over %0d instructions",
                 value_errors, flow_errors, n_accepted);
        if (value_errors == 0 && flow_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Watchdog for 2000 instructions of 20 cycles at 100 ns
    initial
    begin
        #(2000 * 20 * 100);
        $display("timeout: the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10 rst_n = 1'b1;           // Away from both clock edges
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  decode_pkg::insn_t      insn,
    input  decode_pkg::addr_t      pc,
    input  logic                   credit_return,
    input  logic                   flush,
    output logic                   in_ready,
    output logic                   out_valid,
    output decode_pkg::uop_class_e uop_class,
    output decode_pkg::alu_op_e    alu_op,
    output decode_pkg::sub_op_t    sub_op,
    output decode_pkg::reg_idx_t   rj,
    output decode_pkg::reg_idx_t   rk,
    output decode_pkg::reg_idx_t   rd,
    output decode_pkg::imm_t       imm,
    output logic                   src1_pc,
    output logic                   src2_imm,
    output logic                   reg_write,
    output decode_pkg::jump_kind_e jump_kind,
    output decode_pkg::excp_code_t excp_code
);
    import decode_pkg::*;

    uop_class_e dec_uop_class;
    alu_op_e    dec_alu_op;
    sub_op_t    dec_sub_op;
    reg_idx_t   dec_rj;
    reg_idx_t   dec_rk;
    reg_idx_t   dec_rd;
    imm_kind_e  dec_imm_kind;
    imm_t       dec_imm;
    logic       dec_src1_pc;
    logic       dec_src2_imm;
    logic       dec_reg_write;
    jump_kind_e dec_jump_kind;
    excp_code_t dec_excp_code;
    logic       accept;
    logic       has_credit;

    insn_field_decoder insn_field_decoder_inst (
        .insn      (insn),
        .pc        (pc),
        .uop_class (dec_uop_class),
        .alu_op    (dec_alu_op),
        .sub_op    (dec_sub_op),
        .rj        (dec_rj),
        .rk        (dec_rk),
        .rd        (dec_rd),
        .imm_kind  (dec_imm_kind),
        .src1_pc   (dec_src1_pc),
        .src2_imm  (dec_src2_imm),
        .reg_write (dec_reg_write),
        .jump_kind (dec_jump_kind),
        .excp_code (dec_excp_code)
    );

    imm_gen imm_gen_inst (
        .insn     (insn),
        .imm_kind (dec_imm_kind),
        .imm      (dec_imm)
    );

    credit_counter credit_counter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .accept        (accept),
        .credit_return (credit_return),
        .has_credit    (has_credit)
    );

    stage_ctrl stage_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .has_credit (has_credit),
        .uop_class  (dec_uop_class),
        .flush      (flush),
        .in_ready   (in_ready),
        .accept     (accept)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= accept;    // One cycle after the accepting edge
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            uop_class <= dec_uop_class;
            alu_op    <= dec_alu_op;
            sub_op    <= dec_sub_op;
            rj        <= dec_rj;
            rk        <= dec_rk;
            rd        <= dec_rd;
            imm       <= dec_imm;
            src1_pc   <= dec_src1_pc;
            src2_imm  <= dec_src2_imm;
            reg_write <= dec_reg_write;
            jump_kind <= dec_jump_kind;
            excp_code <= dec_excp_code;
        end
    end

endmodule

/* stage_ctrl.sv */
`timescale 1ns/1ps

module stage_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   has_credit,
    input  decode_pkg::uop_class_e uop_class,
    input  logic                   flush,
    output logic                   in_ready,
    output logic                   accept
);
    import decode_pkg::*;

    stage_state_e state;
    stage_state_e state_next;

    assign in_ready = (state == ST_RUN) && has_credit;
    assign accept   = in_valid && in_ready;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_RUN:
            begin
                if (accept && uop_class == UOP_EXCEPTION)
                    state_next = ST_HOLD;   // Wait for the pipeline flush
            end
            default:
            begin
                if (flush)
                    state_next = ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_RUN;
        else
            state <= state_next;
    end

endmodule

/* credit_counter.sv */
`timescale 1ns/1ps

module credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic accept,
    input  logic credit_return,
    output logic has_credit
);
    import decode_pkg::*;

    credit_cnt_t count;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= credit_cnt_t'(CREDITS);
        end
        else if (accept && !credit_return)
        begin
            count <= count - credit_cnt_t'(1);
        end
        else if (!accept && credit_return)
        begin
            count <= count + credit_cnt_t'(1);
        end
    end

    assign has_credit = (count != '0);  // Next send may go out

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::insn_t     insn,
    input  decode_pkg::imm_kind_e imm_kind,
    output decode_pkg::imm_t      imm
);
    import decode_pkg::*;

    always_comb
    begin
        case (imm_kind)
            IMM_UI5:
            begin
                imm = {27'd0, insn[14:10]};
            end
            IMM_SI12:
            begin
                imm = {{20{insn[21]}}, insn[21:10]};
            end
            IMM_UI12:
            begin
                imm = {20'd0, insn[21:10]};
            end
            IMM_HI20:
            begin
                imm = {insn[24:5], 12'd0};  // Upper twenty bits
            end
            IMM_OFFS16:
            begin
                imm = {{14{insn[25]}}, insn[25:10], 2'b00};
            end
            IMM_OFFS26:
            begin
                // High part of the offset sits in 9:0
                imm = {{4{insn[9]}}, insn[9:0], insn[25:10], 2'b00};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

/* insn_field_decoder.sv */
`timescale 1ns/1ps

module insn_field_decoder (
    input  decode_pkg::insn_t      insn,
    input  decode_pkg::addr_t      pc,
    output decode_pkg::uop_class_e uop_class,
    output decode_pkg::alu_op_e    alu_op,
    output decode_pkg::sub_op_t    sub_op,
    output decode_pkg::reg_idx_t   rj,
    output decode_pkg::reg_idx_t   rk,
    output decode_pkg::reg_idx_t   rd,
    output decode_pkg::imm_kind_e  imm_kind,
    output logic                   src1_pc,
    output logic                   src2_imm,
    output logic                   reg_write,
    output decode_pkg::jump_kind_e jump_kind,
    output decode_pkg::excp_code_t excp_code
);
    import decode_pkg::*;

    excp_code_t exc_sel;

    always_comb
    begin
        uop_class = UOP_EXCEPTION;              // Undefined unless matched below
        alu_op    = ALU_AND;
        sub_op    = '0;
        rj        = '0;
        rk        = '0;
        rd        = '0;
        imm_kind  = IMM_NONE;
        src1_pc   = 1'b0;
        src2_imm  = 1'b0;
        reg_write = 1'b0;
        jump_kind = JK_NOT_JUMP;
        exc_sel   = EXC_INE;
        case (insn[31:26])
            6'b000000:
            begin
                case (insn[25:22])
                    4'b0000:
                    begin
                        rk        = insn[14:10];
                        rj        = insn[9:5];
                        rd        = insn[4:0];
                        uop_class = UOP_ALU;
                        reg_write = 1'b1;
                        case (insn[21:15])
                            7'b0100000: alu_op = ALU_ADD;
                            7'b0100010: alu_op = ALU_SUB;
                            7'b0100100: alu_op = ALU_SLT;
                            7'b0100101: alu_op = ALU_SLTU;
                            7'b0101000: alu_op = ALU_NOR;
                            7'b0101001: alu_op = ALU_AND;
                            7'b0101010: alu_op = ALU_OR;
                            7'b0101011: alu_op = ALU_XOR;
                            7'b0101110: alu_op = ALU_SLL;
                            7'b0101111: alu_op = ALU_SRL;
                            7'b0110000: alu_op = ALU_SRA;
                            7'b1010100:
                            begin
                                uop_class = UOP_EXCEPTION;
                                exc_sel   = EXC_BRK;
                            end
                            7'b1010110:
                            begin
                                uop_class = UOP_EXCEPTION;
                                exc_sel   = EXC_SYS;
                            end
                            default: uop_class = UOP_EXCEPTION;
                        endcase
                    end
                    4'b0001:
                    begin
                        // Shift immediates where 19:18 = 11 is reserved
                        if (insn[21:20] == 2'b00 && insn[17:15] == 3'b001 &&
                            insn[19:18] != 2'b11)
                        begin
                            rj        = insn[9:5];
                            rd        = insn[4:0];
                            uop_class = UOP_ALU;
                            reg_write = 1'b1;
                            src2_imm  = 1'b1;
                            imm_kind  = IMM_UI5;
                            case (insn[19:18])
                                2'b00:   alu_op = ALU_SLL;
                                2'b01:   alu_op = ALU_SRL;
                                default: alu_op = ALU_SRA;
                            endcase
                        end
                    end
                    4'b1000, 4'b1001, 4'b1010, 4'b1101, 4'b1110, 4'b1111:
                    begin
                        rj        = insn[9:5];
                        rd        = insn[4:0];
                        uop_class = UOP_ALU;
                        reg_write = 1'b1;
                        src2_imm  = 1'b1;
                        imm_kind  = insn[24] ? IMM_UI12 : IMM_SI12;  // Logic ops zero-extend
                        case (insn[25:22])
                            4'b1000: alu_op = ALU_SLT;
                            4'b1001: alu_op = ALU_SLTU;
                            4'b1010: alu_op = ALU_ADD;
                            4'b1101: alu_op = ALU_AND;
                            4'b1110: alu_op = ALU_OR;
                            default: alu_op = ALU_XOR;
                        endcase
                    end
                    default: ;
                endcase
            end
            6'b000101, 6'b000111:
            begin
                if (!insn[25])
                begin
                    rd        = insn[4:0];
                    uop_class = UOP_ALU;
                    reg_write = 1'b1;
                    src2_imm  = 1'b1;
                    imm_kind  = IMM_HI20;
                    src1_pc   = insn[27];       // PCADDU12I
                    alu_op    = insn[27] ? ALU_ADD : ALU_PASS_B;
                end
            end
            6'b001010:
            begin
                rj       = insn[9:5];
                rd       = insn[4:0];
                src2_imm = 1'b1;
                imm_kind = IMM_SI12;
                alu_op   = ALU_ADD;             // Address is rj + offset
                case (insn[25:22])
                    4'b0000, 4'b0001, 4'b0010, 4'b1000, 4'b1001: uop_class = UOP_LOAD;
                    4'b0100, 4'b0101, 4'b0110: uop_class = UOP_STORE;
                    4'b1011: uop_class = UOP_NOP;   // PRELD
                    default: ;
                endcase
                case (insn[25:22])
                    4'b0001: sub_op = 4'd1;
                    4'b0010: sub_op = 4'd2;
                    4'b0100: sub_op = 4'd3;
                    4'b0101: sub_op = 4'd4;
                    4'b0110: sub_op = 4'd5;
                    4'b1000: sub_op = 4'd6;
                    4'b1001: sub_op = 4'd7;
                    default: sub_op = 4'd0;
                endcase
                reg_write = (uop_class == UOP_LOAD);
            end
            6'b001110:
            begin
                if (insn[25:15] == 11'b00011100100)
                    uop_class = UOP_NOP;        // DBAR
            end
            6'b010011:
            begin
                rj        = insn[9:5];
                rd        = insn[4:0];
                uop_class = UOP_JUMP_LINK;
                reg_write = 1'b1;
                src1_pc   = 1'b1;
                alu_op    = ALU_ADD;
                imm_kind  = IMM_OFFS16;
                if (insn[4:0] == 5'd0 && insn[9:5] == 5'd1 && insn[25:10] == 16'd0)
                    jump_kind = JK_RET;
                else if (insn[4:0] == 5'd1)
                    jump_kind = JK_CALL;
                else
                    jump_kind = JK_INDIRECT;
            end
            6'b010100:
            begin
                uop_class = UOP_BRANCH;         // B
                imm_kind  = IMM_OFFS26;
                jump_kind = JK_JUMP;
            end
            6'b010101:
            begin
                rd        = 5'd1;               // BL links to ra
                uop_class = UOP_JUMP_LINK;
                reg_write = 1'b1;
                src1_pc   = 1'b1;
                alu_op    = ALU_ADD;
                imm_kind  = IMM_OFFS26;
                jump_kind = JK_CALL;
            end
            6'b010110, 6'b010111, 6'b011000, 6'b011001, 6'b011010, 6'b011011:
            begin
                rj        = insn[9:5];
                rd        = insn[4:0];
                uop_class = UOP_BRANCH;
                imm_kind  = IMM_OFFS16;
                jump_kind = JK_DIRECT;
                sub_op    = insn[29:26] - 4'd5; // beq = 1 .. bgeu = 6
                case (insn[29:27])
                    3'b011:  alu_op = ALU_SUB;
                    3'b100:  alu_op = ALU_SLT;
                    default: alu_op = ALU_SLTU;
                endcase
            end
            default: ;
        endcase

        if (pc[1:0] != 2'b00)
        begin
            uop_class = UOP_EXCEPTION;
            exc_sel   = EXC_ADEF;
        end

        // Exceptions and no-ops carry no operands
        if (uop_class == UOP_EXCEPTION || uop_class == UOP_NOP)
        begin
            alu_op    = ALU_AND;
            sub_op    = '0;
            rj        = '0;
            rk        = '0;
            rd        = '0;
            imm_kind  = IMM_NONE;
            src1_pc   = 1'b0;
            src2_imm  = 1'b0;
            reg_write = 1'b0;
            jump_kind = JK_NOT_JUMP;
        end
    end

    assign excp_code = (uop_class == UOP_EXCEPTION) ? exc_sel : '0;

endmodule

/* decode_pkg.sv */
package decode_pkg;

    localparam int INSN_W    = 32;
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int EXCP_W    = 6;
    localparam int SUB_OP_W  = 4;
    localparam int CREDIT_W  = 3;

    typedef logic [INSN_W-1:0]    insn_t;
    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      imm_t;
    typedef logic [EXCP_W-1:0]    excp_code_t;
    typedef logic [SUB_OP_W-1:0]  sub_op_t;     // Branch cond or mem size/sign
    typedef logic [CREDIT_W-1:0]  credit_cnt_t;

    localparam excp_code_t EXC_ADEF = 6'd8;
    localparam excp_code_t EXC_SYS  = 6'd11;
    localparam excp_code_t EXC_BRK  = 6'd12;
    localparam excp_code_t EXC_INE  = 6'd13;

    localparam int CREDITS = 4;                 // Granted by downstream stage

    typedef enum logic [2:0] {
        UOP_ALU,
        UOP_BRANCH,
        UOP_JUMP_LINK,
        UOP_LOAD,
        UOP_STORE,
        UOP_EXCEPTION,
        UOP_NOP
    } uop_class_e;

    typedef enum logic [3:0] {
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    // Hint for the branch predictor
    typedef enum logic [2:0] {
        JK_NOT_JUMP,
        JK_DIRECT,
        JK_JUMP,
        JK_CALL,
        JK_RET,
        JK_INDIRECT
    } jump_kind_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_UI5,
        IMM_SI12,
        IMM_UI12,
        IMM_HI20,
        IMM_OFFS16,                             // Word offsets are shifted left by two
        IMM_OFFS26
    } imm_kind_e;

    typedef enum logic {
        ST_RUN,
        ST_HOLD
    } stage_state_e;

endpackage
